// File: design/cache_way.sv
`timescale 1ns/100ps

module cache_way (
    input  logic                clk,
    input  logic                rst_n,
    // lookup read
    input  logic                rd_en_i,
    input  dcache_pkg::index_t  rd_index_i,
    input  dcache_pkg::tag_t    lookup_tag_i,
    // write command from the controller
    input  dcache_pkg::way_wr_t wr_i,
    // lookup result
    output dcache_pkg::way_rd_t rd_o
);
    import dcache_pkg::*;

    tag_entry_t entry_q;
    tag_entry_t new_entry;
    line_t      line_q;
    line_t      base_line;
    line_t      new_line;

    ////////////////////////////////
    // storage
    ////////////////////////////////
    way_ram #(
        .T(tag_entry_t)
    ) tag_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en_i    (rd_en_i),
        .rd_index_i (rd_index_i),
        .rd_data_o  (entry_q),
        .wr_en_i    (wr_i.valid),
        .wr_index_i (wr_i.index),
        .wr_data_i  (new_entry)
    );

    // all 8 banks of the line side by side
    way_ram #(
        .T(line_t)
    ) data_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en_i    (rd_en_i),
        .rd_index_i (rd_index_i),
        .rd_data_o  (line_q),
        .wr_en_i    (wr_i.valid),
        .wr_index_i (wr_i.index),
        .wr_data_i  (new_line)
    );

    ////////////////////////////////
    // write path
    ////////////////////////////////
    always_comb begin
        // refill line or the resident line for a write hit
        base_line = wr_i.fill ? wr_i.fill_line : line_q;
        new_line  = base_line;
        for (int b = 0; b < STRB_W; b++) begin
            if (wr_i.wstrb[b]) begin
                new_line[wr_i.word][8*b +: 8] = wr_i.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        new_entry.valid = 1'b1;
        new_entry.dirty = wr_i.dirty;
        new_entry.tag   = wr_i.tag;
    end

    ////////////////////////////////
    // tag compare
    ////////////////////////////////
    always_comb begin
        rd_o.hit   = entry_q.valid && (entry_q.tag == lookup_tag_i);
        rd_o.entry = entry_q;
        rd_o.line  = line_q;
    end

endmodule

// File: design/dcache_lookup.sv
`timescale 1ns/100ps

module dcache_lookup (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dcache_pkg::cpu_req_t  cpu_req_i,
    output logic                  req_ready_o,
    output dcache_pkg::cpu_rsp_t  cpu_rsp_o,
    output dcache_pkg::miss_req_t miss_req_o,
    input  dcache_pkg::refill_t   refill_i
);
    import dcache_pkg::*;

    logic    rd_en;
    index_t  rd_index;
    tag_t    lookup_tag;
    way_rd_t way0_rd;
    way_rd_t way1_rd;
    way_wr_t way0_wr;
    way_wr_t way1_wr;

    // the controller picks between two identical ways
    cache_way way0_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en_i      (rd_en),
        .rd_index_i   (rd_index),
        .lookup_tag_i (lookup_tag),
        .wr_i         (way0_wr),
        .rd_o         (way0_rd)
    );

    cache_way way1_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en_i      (rd_en),
        .rd_index_i   (rd_index),
        .lookup_tag_i (lookup_tag),
        .wr_i         (way1_wr),
        .rd_o         (way1_rd)
    );

    lookup_ctrl ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req_i    (cpu_req_i),
        .req_ready_o  (req_ready_o),
        .cpu_rsp_o    (cpu_rsp_o),
        .rd_en_o      (rd_en),
        .rd_index_o   (rd_index),
        .lookup_tag_o (lookup_tag),
        .way0_rd_i    (way0_rd),
        .way1_rd_i    (way1_rd),
        .way0_wr_o    (way0_wr),
        .way1_wr_o    (way1_wr),
        .miss_req_o   (miss_req_o),
        .refill_i     (refill_i)
    );

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////
    // geometry
    ////////////////////////////////
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;
    localparam int INDEX_W        = 6;
    localparam int NUM_SETS       = 64;
    localparam int TAG_W          = 21;
    localparam int STRB_W         = 4;

    // address fields
    typedef logic [TAG_W-1:0]                      tag_t;
    typedef logic [INDEX_W-1:0]                    index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]     word_sel_t;
    typedef logic [WORDS_PER_LINE-1:0][DATA_W-1:0] line_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    ////////////////////////////////
    // external interfaces
    ////////////////////////////////
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        logic              hit;
        logic [DATA_W-1:0] rdata;
    } cpu_rsp_t;

    // with wb set the victim goes to memory before the refill
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] line_addr;
        logic              wb;
        logic [ADDR_W-1:0] wb_addr;
        line_t             wb_line;
    } miss_req_t;

    typedef struct packed {
        logic  valid;
        line_t line;
    } refill_t;

    ////////////////////////////////
    // controller <-> way
    ////////////////////////////////
    typedef struct packed {
        logic              valid;
        index_t            index;
        logic              fill;
        line_t             fill_line;
        tag_t              tag;
        logic              dirty;
        word_sel_t         word;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } way_wr_t;

    typedef struct packed {
        logic       hit;
        tag_entry_t entry;
        line_t      line;
    } way_rd_t;

endpackage

// File: design/lookup_ctrl.sv
`timescale 1ns/100ps

module lookup_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    // cpu side
    input  dcache_pkg::cpu_req_t  cpu_req_i,
    output logic                  req_ready_o,
    output dcache_pkg::cpu_rsp_t  cpu_rsp_o,
    // storage read for the next request
    output logic                  rd_en_o,
    output dcache_pkg::index_t    rd_index_o,
    output dcache_pkg::tag_t      lookup_tag_o,
    // ways
    input  dcache_pkg::way_rd_t   way0_rd_i,
    input  dcache_pkg::way_rd_t   way1_rd_i,
    output dcache_pkg::way_wr_t   way0_wr_o,
    output dcache_pkg::way_wr_t   way1_wr_o,
    // memory side
    output dcache_pkg::miss_req_t miss_req_o,
    input  dcache_pkg::refill_t   refill_i
);
    import dcache_pkg::*;

    cpu_req_t            s2_req;
    logic [NUM_SETS-1:0] lru_q;
    index_t              s2_index;
    word_sel_t           s2_word;
    logic                accept;
    logic                hit;
    logic                miss;
    logic                refill_done;
    logic                victim;
    way_rd_t             hit_rd;
    way_rd_t             victim_rd;
    way_wr_t             wr_cmd;

    ////////////////////////////////
    // accept and stage two
    ////////////////////////////////
    // only a pending miss holds off new requests
    assign req_ready_o = !miss;
    assign accept      = cpu_req_i.valid && req_ready_o;
    assign rd_en_o     = accept;
    assign rd_index_o  = cpu_req_i.addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_req <= '0;
        end else if (accept) begin
            s2_req <= cpu_req_i;
        end else if (hit || refill_done) begin
            s2_req.valid <= 1'b0;
        end
    end

    assign s2_index     = s2_req.addr[OFFSET_W +: INDEX_W];
    assign s2_word      = s2_req.addr[$clog2(STRB_W) +: $bits(word_sel_t)];
    assign lookup_tag_o = s2_req.addr[ADDR_W-1 -: TAG_W];

    // way0 wins the hit combine
    assign hit         = s2_req.valid && (way0_rd_i.hit || way1_rd_i.hit);
    assign miss        = s2_req.valid && !hit;
    assign refill_done = miss && refill_i.valid;
    assign hit_rd      = way0_rd_i.hit ? way0_rd_i : way1_rd_i;

    ////////////////////////////////
    // LRU bit names the victim way
    ////////////////////////////////
    assign victim    = lru_q[s2_index];
    assign victim_rd = victim ? way1_rd_i : way0_rd_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (hit) begin
            // victim becomes the way not hit
            lru_q[s2_index] <= way0_rd_i.hit;
        end else if (refill_done) begin
            lru_q[s2_index] <= !victim;
        end
    end

    ////////////////////////////////
    // way write commands
    ////////////////////////////////
    always_comb begin
        wr_cmd.valid     = 1'b0;
        wr_cmd.index     = s2_index;
        wr_cmd.fill      = refill_done;
        wr_cmd.fill_line = refill_i.line;
        wr_cmd.tag       = lookup_tag_o;
        // write hit or write miss both leave the line dirty
        wr_cmd.dirty     = s2_req.write;
        wr_cmd.word      = s2_word;
        wr_cmd.wdata     = s2_req.wdata;
        wr_cmd.wstrb     = s2_req.write ? s2_req.wstrb : '0;

        way0_wr_o       = wr_cmd;
        way1_wr_o       = wr_cmd;
        way0_wr_o.valid = (hit && s2_req.write && way0_rd_i.hit)
                          || (refill_done && !victim);
        way1_wr_o.valid = (hit && s2_req.write && !way0_rd_i.hit)
                          || (refill_done && victim);
    end

    ////////////////////////////////
    // responses
    ////////////////////////////////
    always_comb begin
        cpu_rsp_o.valid = hit || refill_done;
        cpu_rsp_o.hit   = hit;
        // on refill the word comes straight from memory
        cpu_rsp_o.rdata = hit ? hit_rd.line[s2_word] : refill_i.line[s2_word];
    end

    always_comb begin
        miss_req_o.valid     = miss;
        miss_req_o.line_addr = {lookup_tag_o, s2_index, {OFFSET_W{1'b0}}};
        miss_req_o.wb        = victim_rd.entry.valid && victim_rd.entry.dirty;
        miss_req_o.wb_addr   = {victim_rd.entry.tag, s2_index, {OFFSET_W{1'b0}}};
        miss_req_o.wb_line   = victim_rd.line;
    end

endmodule

// File: design/way_ram.sv
`timescale 1ns/100ps

module way_ram #(
    parameter type T = dcache_pkg::tag_entry_t
) (
    input  logic               clk,
    input  logic               rst_n,
    // read side
    input  logic               rd_en_i,
    input  dcache_pkg::index_t rd_index_i,
    output T                   rd_data_o,
    // write side
    input  logic               wr_en_i,
    input  dcache_pkg::index_t wr_index_i,
    input  T                   wr_data_i
);
    import dcache_pkg::*;

    T     mem [NUM_SETS];
    T     rd_q;
    logic colli;

    // new data wins when the same set is written and read
    assign colli = wr_en_i && (wr_index_i == rd_index_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem[i] <= '0;
            end
            rd_q <= '0;
        end else begin
            if (wr_en_i) begin
                mem[wr_index_i] <= wr_data_i;
            end
            // output holds between enabled reads
            if (rd_en_i) begin
                rd_q <= colli ? wr_data_i : mem[rd_index_i];
            end
        end
    end

    assign rd_data_o = rd_q;

endmodule

// File: list.f
design/dcache_pkg.sv
design/way_ram.sv
design/cache_way.sv
design/lookup_ctrl.sv
design/dcache_lookup.sv
tests/tb_dcache_lookup.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dcache_lookup -f list.f \
    --Mdir obj_dir -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: tests/tb_dcache_lookup.sv
`timescale 1ns/100ps

module tb_dcache_lookup;
    import dcache_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      rst_n;
    cpu_req_t  cpu_req_i;
    logic      req_ready_o;
    cpu_rsp_t  cpu_rsp_o;
    miss_req_t miss_req_o;
    refill_t   refill_i;

    int          errors;
    int          checks;
    int          cycles;
    int          wait_cnt;
    int          miss_cnt;
    logic [31:0] seed;

    // backing memory and the data the cpu expects to see
    logic [31:0] mem_q    [logic [29:0]];
    logic [31:0] shadow_q [logic [29:0]];

    // last miss seen by the memory model
    logic [31:0] miss_line_addr;
    logic        miss_wb;
    logic [31:0] miss_wb_addr;
    line_t       miss_wb_line;

    // last response
    logic        rsp_hit;
    logic [31:0] rsp_data;
    int          rsp_lat;

    // stream stimulus
    logic        s_write [64];
    logic [31:0] s_addr  [64];
    logic [31:0] s_wdata [64];
    logic [3:0]  s_strb  [64];

    dcache_lookup dcache_lookup_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req_i   (cpu_req_i),
        .req_ready_o (req_ready_o),
        .cpu_rsp_o   (cpu_rsp_o),
        .miss_req_o  (miss_req_o),
        .refill_i    (refill_i)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a response never arrived", cycles);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////
    // memory model
    //////////////////////////////
    function automatic logic [31:0] default_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem_q.exists(addr[31:2])) begin
            return mem_q[addr[31:2]];
        end
        return default_word(addr);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow_q.exists(addr[31:2])) begin
            return shadow_q[addr[31:2]];
        end
        return default_word(addr);
    endfunction

    function automatic void shadow_store(input logic [31:0] addr, input logic [31:0] data,
                                         input logic [3:0] strb);
        logic [31:0] w;
        w = shadow_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow_q[addr[31:2]] = w;
    endfunction

    // refill answers a few cycles after the miss shows up
    always @(negedge clk) begin
        if (refill_i.valid) begin
            refill_i = '0;
            wait_cnt = 0;
        end else if (miss_req_o.valid) begin
            wait_cnt++;
            if (wait_cnt == 3) begin
                miss_cnt++;
                miss_line_addr = miss_req_o.line_addr;
                miss_wb        = miss_req_o.wb;
                miss_wb_addr   = miss_req_o.wb_addr;
                miss_wb_line   = miss_req_o.wb_line;
                if (miss_req_o.wb) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        mem_q[miss_req_o.wb_addr[31:2] + 30'(w)] = miss_req_o.wb_line[w];
                    end
                end
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    refill_i.line[w] = mem_word(miss_req_o.line_addr + 32'(4 * w));
                end
                refill_i.valid = 1'b1;
            end
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic check(input logic [255:0] got, input logic [255:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // one request that waits for acceptance and then for its response
    task automatic do_req(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb);
        @(negedge clk);
        cpu_req_i.valid = 1'b1;
        cpu_req_i.write = write;
        cpu_req_i.addr  = addr;
        cpu_req_i.wdata = wdata;
        cpu_req_i.wstrb = strb;
        #3;
        while (!req_ready_o) begin
            @(negedge clk);
            #3;
        end
        @(negedge clk);
        cpu_req_i = '0;
        rsp_lat   = 1;
        #3;
        while (!cpu_rsp_o.valid) begin
            // a pending miss holds the request side off
            check(256'(miss_req_o.valid), 256'(1), "miss request while waiting");
            check(256'(req_ready_o), 256'(0), "ready low during miss");
            rsp_lat++;
            @(negedge clk);
            #3;
        end
        rsp_hit  = cpu_rsp_o.hit;
        rsp_data = cpu_rsp_o.rdata;
        if (!rsp_hit) begin
            check(256'(req_ready_o), 256'(0), "ready low in refill cycle");
            @(negedge clk);
            #3;
            check(256'(req_ready_o), 256'(1), "ready back after refill");
        end
    endtask

    task automatic access(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, input logic exp_hit, input string msg);
        logic [31:0] exp_data;
        exp_data = shadow_word(addr);
        do_req(write, addr, wdata, strb);
        check(256'(rsp_hit), 256'(exp_hit), {msg, " hit flag"});
        if (!write) begin
            check(256'(rsp_data), 256'(exp_data), {msg, " read data"});
        end
        if (exp_hit) begin
            check(256'(rsp_lat), 256'(1), {msg, " hit latency"});
        end
        if (write) begin
            shadow_store(addr, wdata, strb);
        end
    endtask

    // one request per cycle and all expected to hit
    task automatic run_stream(input int n);
        logic [31:0] exp_data [64];
        for (int i = 0; i < n; i++) begin
            exp_data[i] = shadow_word(s_addr[i]);
            if (s_write[i]) begin
                shadow_store(s_addr[i], s_wdata[i], s_strb[i]);
            end
        end
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i < n) begin
                cpu_req_i.valid = 1'b1;
                cpu_req_i.write = s_write[i];
                cpu_req_i.addr  = s_addr[i];
                cpu_req_i.wdata = s_wdata[i];
                cpu_req_i.wstrb = s_strb[i];
            end else begin
                cpu_req_i = '0;
            end
            #3;
            if (i < n) begin
                check(256'(req_ready_o), 256'(1), "stream ready");
            end
            if (i > 0) begin
                check(256'(cpu_rsp_o.valid), 256'(1), "stream response valid");
                check(256'(cpu_rsp_o.hit), 256'(1), "stream hit");
                if (!s_write[i-1]) begin
                    check(256'(cpu_rsp_o.rdata), 256'(exp_data[i-1]), "stream read data");
                end
            end
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////
    task automatic cold_read_then_hit();
        access(1'b0, 32'h0000_1044, '0, '0, 1'b0, "cold read");
        check(256'(miss_line_addr), 256'(32'h0000_1040), "cold read line_addr");
        check(256'(miss_wb), 256'(0), "cold read wb");
        access(1'b0, 32'h0000_1048, '0, '0, 1'b1, "second read");
    endtask

    task automatic write_read_forward();
        s_write[0] = 1'b1;
        s_addr[0]  = 32'h0000_1044;
        s_wdata[0] = 32'hdeadbeef;
        s_strb[0]  = 4'b0101;
        s_write[1] = 1'b0;
        s_addr[1]  = 32'h0000_1044;
        s_wdata[1] = '0;
        s_strb[1]  = '0;
        run_stream(2);
    endtask

    task automatic write_miss_eviction();
        line_t exp_line;
        access(1'b1, 32'h0001_00a8, 32'h1234_5678, 4'b1110, 1'b0, "write miss");
        access(1'b0, 32'h0002_00a0, '0, '0, 1'b0, "second miss");
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp_line[w] = shadow_word(32'h0001_00a0 + 32'(4 * w));
        end
        access(1'b0, 32'h0003_00a4, '0, '0, 1'b0, "evicting miss");
        check(256'(miss_wb), 256'(1), "evict wb");
        check(256'(miss_wb_addr), 256'(32'h0001_00a0), "evict wb_addr");
        check(miss_wb_line, exp_line, "evict wb_line");
        access(1'b0, 32'h0001_00a8, '0, '0, 1'b0, "reload written line");
    endtask

    task automatic lru_replacement();
        access(1'b0, 32'h0004_0120, '0, '0, 1'b0, "lru fill A");
        access(1'b0, 32'h0005_0120, '0, '0, 1'b0, "lru fill B");
        access(1'b0, 32'h0004_0124, '0, '0, 1'b1, "lru hit A");
        access(1'b0, 32'h0006_0120, '0, '0, 1'b0, "lru miss C");
        check(256'(miss_wb), 256'(0), "lru clean victim");
        access(1'b0, 32'h0004_0128, '0, '0, 1'b1, "lru A kept");
        access(1'b0, 32'h0005_0128, '0, '0, 1'b0, "lru B evicted");
    endtask

    task automatic random_hit_stream();
        logic [31:0] bases [3];
        logic [31:0] r;
        int          pick;
        bases[0] = 32'h0000_1040;
        bases[1] = 32'h0004_0120;
        bases[2] = 32'h0005_0120;
        for (int i = 0; i < 24; i++) begin
            r          = $random(seed);
            pick       = int'($unsigned(r[15:8]) % 3);
            s_addr[i]  = bases[pick] | {27'd0, r[2:0], 2'b00};
            s_write[i] = r[3];
            s_strb[i]  = r[7:4];
            s_wdata[i] = $random(seed);
        end
        run_stream(24);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_req_i = '0;
        refill_i  = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        wait_cnt  = 0;
        miss_cnt  = 0;
        seed      = 32'he111;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #3;
        check(256'(req_ready_o), 256'(1), "ready after reset");
        check(256'(cpu_rsp_o.valid), 256'(0), "no response after reset");
        check(256'(miss_req_o.valid), 256'(0), "no miss after reset");

        cold_read_then_hit();
        write_read_forward();
        write_miss_eviction();
        lru_replacement();
        random_hit_stream();

        repeat (2) @(negedge clk);
        $display("errors: %0d of %0d checks, misses served: %0d", errors, checks, miss_cnt);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
